/* run_sim.sh */
#!/bin/sh
# build and run the xip testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f xip.f --top-module xip_tb -o xip_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/xip_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1

/* xip.f */
+incdir+.
xip_pkg.sv
xip_ifs.sv
xip_ctrl_regs.sv
xip_fetch.sv
xip_spi_arbiter.sv
xip_spi_phy.sv
xip_top.sv
xip_props.sv
xip_tb.sv

/* xip_consts.svh */
// --------------------------------------------------------------------------
// XIP register map and field constants
// --------------------------------------------------------------------------
`ifndef XIP_CONSTS_SVH
`define XIP_CONSTS_SVH

// register word offsets
`define XIP_REG_CTRL        2'd0
`define XIP_REG_DATA_LO     2'd2
`define XIP_REG_DATA_HI     2'd3

// control register bit positions
`define XIP_CTRL_ENABLE     0   // module enable
`define XIP_CTRL_PRSC_LSB   1   // spi clock divider select, 3 bits
`define XIP_CTRL_NBYTES_LSB 6   // direct transfer length 1..9, 4 bits
`define XIP_CTRL_XIP_EN     10  // memory window enable
`define XIP_CTRL_ABYTES_LSB 11  // address bytes minus one, 2 bits
`define XIP_CTRL_RDCMD_LSB  13  // flash read command, 8 bits
`define XIP_CTRL_PAGE_LSB   21  // memory page, 4 bits
`define XIP_CTRL_PHY_BUSY   30  // read only, direct transfer pending
`define XIP_CTRL_XIP_BUSY   31  // read only, fetch in flight

// field widths
`define XIP_WORD_BITS       32
`define XIP_REG_ADDR_BITS   2
`define XIP_PAGE_BITS       4
`define XIP_PRSC_BITS       3
`define XIP_NBYTES_BITS     4
`define XIP_ABYTES_BITS     2
`define XIP_CMD_BITS        8
`define XIP_FRAME_BITS      72  // cmd + up to 8 more bytes

`endif

/* xip_ctrl_regs.sv */
// --------------------------------------------------------------------------
// XIP control and direct access registers
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "xip_consts.svh"

module xip_ctrl_regs (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  xip_pkg::reg_addr_t ct_addr_i,     // register word address
    input  logic               ct_rden_i,     // read strobe
    input  logic               ct_wren_i,     // write strobe
    input  xip_pkg::word_t     ct_data_i,
    output xip_pkg::word_t     ct_data_o,     // zero outside the ack cycle
    output logic               ct_ack_o,
    input  logic               fetch_busy_i,  // status bit 31
    output logic               enable_o,
    output logic               xip_active_o,  // enable and xip enable
    output xip_pkg::prsc_t     prsc_o,
    output xip_pkg::abytes_t   abytes_o,
    output xip_pkg::cmd_t      rd_cmd_o,
    output xip_pkg::page_t     page_o,
    xip_req_if.requester       direct_req
);
    import xip_pkg::*;

    logic    xip_en_q;
    nbytes_t nbytes_q;      // control field
    nbytes_t req_nbytes_q;  // length of the pending transfer
    word_t   data_lo_q;
    word_t   data_hi_q;
    word_t   rx_data_q;     // last received word
    logic    pending_q;     // direct transfer waiting or running
    logic    trigger;
    word_t   ctrl_word;

    assign trigger = ct_wren_i && (ct_addr_i == `XIP_REG_DATA_HI) && !pending_q;

    // ----------------------------------------------------------------------
    // control fields and pending flag
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_o  <= 1'b0;
            prsc_o    <= '0;
            nbytes_q  <= '0;
            xip_en_q  <= 1'b0;
            abytes_o  <= '0;
            rd_cmd_o  <= '0;
            page_o    <= '0;
            pending_q <= 1'b0;
        end else begin
            if (ct_wren_i && (ct_addr_i == `XIP_REG_CTRL)) begin
                enable_o <= ct_data_i[`XIP_CTRL_ENABLE];
                prsc_o   <= ct_data_i[`XIP_CTRL_PRSC_LSB +: `XIP_PRSC_BITS];
                nbytes_q <= ct_data_i[`XIP_CTRL_NBYTES_LSB +: `XIP_NBYTES_BITS];
                xip_en_q <= ct_data_i[`XIP_CTRL_XIP_EN];
                abytes_o <= ct_data_i[`XIP_CTRL_ABYTES_LSB +: `XIP_ABYTES_BITS];
                rd_cmd_o <= ct_data_i[`XIP_CTRL_RDCMD_LSB +: `XIP_CMD_BITS];
                page_o   <= ct_data_i[`XIP_CTRL_PAGE_LSB +: `XIP_PAGE_BITS];
            end
            if (trigger) begin
                pending_q <= 1'b1;                  // raises req
            end else if (direct_req.done) begin
                pending_q <= 1'b0;                  // req low the next cycle
            end
        end
    end

    // data words, frozen while a transfer is pending
    always_ff @(posedge clk_i) begin
        if (ct_wren_i && !pending_q) begin
            if (ct_addr_i == `XIP_REG_DATA_LO) data_lo_q <= ct_data_i;
            if (ct_addr_i == `XIP_REG_DATA_HI) data_hi_q <= ct_data_i;
        end
        if (trigger) req_nbytes_q <= nbytes_q;
        if (direct_req.done) rx_data_q <= direct_req.rdata;
    end

    // ----------------------------------------------------------------------
    // readback
    always_comb begin
        ctrl_word                                               = '0;
        ctrl_word[`XIP_CTRL_ENABLE]                             = enable_o;
        ctrl_word[`XIP_CTRL_PRSC_LSB +: `XIP_PRSC_BITS]         = prsc_o;
        ctrl_word[`XIP_CTRL_NBYTES_LSB +: `XIP_NBYTES_BITS]     = nbytes_q;
        ctrl_word[`XIP_CTRL_XIP_EN]                             = xip_en_q;
        ctrl_word[`XIP_CTRL_ABYTES_LSB +: `XIP_ABYTES_BITS]     = abytes_o;
        ctrl_word[`XIP_CTRL_RDCMD_LSB +: `XIP_CMD_BITS]         = rd_cmd_o;
        ctrl_word[`XIP_CTRL_PAGE_LSB +: `XIP_PAGE_BITS]         = page_o;
        ctrl_word[`XIP_CTRL_PHY_BUSY]                           = pending_q;
        ctrl_word[`XIP_CTRL_XIP_BUSY]                           = fetch_busy_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ct_ack_o  <= 1'b0;
            ct_data_o <= '0;
        end else begin
            ct_ack_o  <= ct_rden_i | ct_wren_i;     // one cycle after either strobe
            ct_data_o <= '0;
            if (ct_rden_i) begin
                case (ct_addr_i)
                    `XIP_REG_CTRL:    ct_data_o <= ctrl_word;
                    `XIP_REG_DATA_LO: ct_data_o <= rx_data_q;
                    default:          ct_data_o <= '0;    // data hi is write only
                endcase
            end
        end
    end

    assign xip_active_o      = enable_o & xip_en_q;
    assign direct_req.req    = pending_q;
    assign direct_req.nbytes = req_nbytes_q;
    assign direct_req.frame  = {data_hi_q, data_lo_q, 8'h00};   // msb aligned

endmodule

`default_nettype wire

/* xip_fetch.sv */
// --------------------------------------------------------------------------
// XIP fetch port sequencer
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module xip_fetch (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  xip_pkg::word_t   acc_addr_i,
    input  logic             acc_rden_i,
    input  logic             acc_wren_i,
    input  logic             xip_active_i,
    input  xip_pkg::page_t   page_i,
    input  xip_pkg::abytes_t abytes_i,
    input  xip_pkg::cmd_t    rd_cmd_i,
    output xip_pkg::word_t   acc_data_o,    // little endian read data
    output logic             acc_ack_o,
    output logic             acc_err_o,     // write into the window
    output logic             busy_o,
    xip_req_if.requester     fetch_req
);
    import xip_pkg::*;

    fetch_state_t state_q;
    word_t        addr_q;
    word_t        offset;
    logic         page_hit;

    assign page_hit = xip_active_i && (acc_addr_i[31:28] == page_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= F_IDLE;
        end else begin
            case (state_q)
                F_IDLE: begin
                    if (page_hit && acc_rden_i) begin
                        state_q <= F_WAIT;
                    end else if (page_hit && acc_wren_i) begin
                        state_q <= F_ERROR;
                    end
                end
                F_WAIT:  if (fetch_req.done) state_q <= F_IDLE;
                default: state_q <= F_IDLE;     // error lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == F_IDLE) && page_hit && acc_rden_i) addr_q <= acc_addr_i;
    end

    // ----------------------------------------------------------------------
    // flash frame, cmd then word aligned offset then dummy data bytes
    assign offset = {4'h0, addr_q[27:2], 2'b00};

    always_comb begin
        case (abytes_i)
            2'd0:    fetch_req.frame = {rd_cmd_i, offset[7:0], 56'h0};
            2'd1:    fetch_req.frame = {rd_cmd_i, offset[15:0], 48'h0};
            2'd2:    fetch_req.frame = {rd_cmd_i, offset[23:0], 40'h0};
            default: fetch_req.frame = {rd_cmd_i, offset, 32'h0};
        endcase
    end

    assign fetch_req.req    = (state_q == F_WAIT);
    assign fetch_req.nbytes = nbytes_t'(abytes_i) + nbytes_t'(6);  // cmd + addr + 4 data

    // first flash byte lands in the low byte
    assign acc_ack_o  = fetch_req.req && fetch_req.done;
    assign acc_data_o = acc_ack_o ? {fetch_req.rdata[7:0], fetch_req.rdata[15:8],
                                     fetch_req.rdata[23:16], fetch_req.rdata[31:24]} : '0;
    assign acc_err_o  = (state_q == F_ERROR);
    assign busy_o     = fetch_req.req;

endmodule

`default_nettype wire

/* xip_ifs.sv */
// --------------------------------------------------------------------------
// XIP requester and shift engine interfaces
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

// requester to arbiter, req held until done
interface xip_req_if;
    import xip_pkg::*;

    logic    req;       // level, held until done
    nbytes_t nbytes;    // transfer length
    frame_t  frame;     // msb aligned tx data
    logic    done;      // one cycle, transfer finished
    word_t   rdata;     // last 32 rx bits, valid with done

    modport requester (output req, nbytes, frame, input done, rdata);
    modport arbiter   (input req, nbytes, frame, output done, rdata);
endinterface

// arbiter to shift engine
interface xip_phy_if;
    import xip_pkg::*;

    logic    start;     // one cycle, only while not busy
    nbytes_t nbytes;
    frame_t  wdata;
    logic    busy;      // rises the cycle after start
    word_t   rdata;     // valid once busy falls

    modport ctrl (output start, nbytes, wdata, input busy, rdata);
    modport phy  (input start, nbytes, wdata, output busy, rdata);
endinterface

`default_nettype wire

/* xip_pkg.sv */
// --------------------------------------------------------------------------
// XIP shared types
// --------------------------------------------------------------------------
`default_nettype none

`include "xip_consts.svh"

package xip_pkg;

    typedef logic [`XIP_WORD_BITS-1:0]     word_t;      // data and address word
    typedef logic [`XIP_REG_ADDR_BITS-1:0] reg_addr_t;  // register word address
    typedef logic [`XIP_PAGE_BITS-1:0]     page_t;      // top address nibble
    typedef logic [`XIP_PRSC_BITS-1:0]     prsc_t;      // half period = 2^prsc cycles
    typedef logic [`XIP_NBYTES_BITS-1:0]   nbytes_t;    // bytes per transfer
    typedef logic [`XIP_ABYTES_BITS-1:0]   abytes_t;    // address bytes minus one
    typedef logic [`XIP_CMD_BITS-1:0]      cmd_t;       // spi command byte
    typedef logic [`XIP_FRAME_BITS-1:0]    frame_t;     // msb aligned tx frame

    // fetch port sequencer
    typedef enum logic [1:0] {
        F_IDLE,     // watching the strobes
        F_WAIT,     // flash read requested
        F_ERROR     // write into window, one cycle error
    } fetch_state_t;

endpackage

`default_nettype wire

/* xip_props.sv */
// --------------------------------------------------------------------------
// XIP interface properties
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module xip_props (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             ct_rden_i,
    input  logic             ct_wren_i,
    input  logic             ct_ack_i,
    input  xip_pkg::word_t   acc_addr_i,
    input  logic             acc_wren_i,
    input  logic             acc_ack_i,
    input  logic             acc_err_i,
    input  logic             acc_busy_i,    // fetch in flight
    input  logic             xip_active_i,  // enable and window enable
    input  xip_pkg::page_t   page_i,
    input  logic             xip_en_i,
    input  logic             spi_csn_i
);
    import xip_pkg::*;

    logic page_write;   // write the fetch side can see

    assign page_write = acc_wren_i && xip_active_i && !acc_busy_i && !acc_err_i
                        && (acc_addr_i[31:28] == page_i);

    ack_follows_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ct_rden_i || ct_wren_i) |=> ct_ack_i)
        else $error("register strobe not acknowledged one cycle later");

    ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(acc_ack_i && acc_err_i))
        else $error("fetch ack and error high together");

    csn_idle_when_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (!xip_en_i && $past(!xip_en_i)) |-> spi_csn_i)
        else $error("chip select low while the controller is disabled");

    err_follows_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        page_write |=> acc_err_i)
        else $error("write into the window without error pulse");

endmodule

bind xip_top xip_props u_props (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .ct_rden_i    (ct_rden_i),
    .ct_wren_i    (ct_wren_i),
    .ct_ack_i     (ct_ack_o),
    .acc_addr_i   (acc_addr_i),
    .acc_wren_i   (acc_wren_i),
    .acc_ack_i    (acc_ack_o),
    .acc_err_i    (acc_err_o),
    .acc_busy_i   (xip_acc_o),
    .xip_active_i (xip_active),
    .page_i       (xip_page_o),
    .xip_en_i     (xip_en_o),
    .spi_csn_i    (spi_csn_o)
);

`default_nettype wire

/* xip_spi_arbiter.sv */
// --------------------------------------------------------------------------
// XIP shift engine arbiter
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module xip_spi_arbiter (
    input  logic       clk_i,
    input  logic       rstn_i,
    xip_req_if.arbiter fetch_req,     // higher priority
    xip_req_if.arbiter direct_req,
    xip_phy_if.ctrl    phy
);
    typedef enum logic [1:0] {
        G_NONE,
        G_FETCH,
        G_DIRECT
    } grant_t;

    grant_t grant_q;
    logic   launch;     // start pulse this cycle
    logic   finish;     // granted transfer over

    // busy is high from the cycle after launch until the last bit
    assign launch = (grant_q == G_NONE) && !phy.busy && (fetch_req.req || direct_req.req);
    assign finish = (grant_q != G_NONE) && !phy.busy;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            grant_q <= G_NONE;
        end else if (launch) begin
            grant_q <= fetch_req.req ? G_FETCH : G_DIRECT;
        end else if (finish) begin
            grant_q <= G_NONE;
        end
    end

    assign phy.start  = launch;
    assign phy.wdata  = fetch_req.req ? fetch_req.frame : direct_req.frame;    // taken at start
    assign phy.nbytes = fetch_req.req ? fetch_req.nbytes : direct_req.nbytes;

    assign fetch_req.done   = finish && (grant_q == G_FETCH);
    assign direct_req.done  = finish && (grant_q == G_DIRECT);
    assign fetch_req.rdata  = phy.rdata;
    assign direct_req.rdata = phy.rdata;

endmodule

`default_nettype wire

/* xip_spi_phy.sv */
// --------------------------------------------------------------------------
// XIP SPI mode 0 shift engine
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "xip_consts.svh"

module xip_spi_phy (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           enable_i,    // low holds the engine idle
    input  xip_pkg::prsc_t prsc_i,      // half period = 2^prsc cycles
    input  logic           spi_dat_i,
    xip_phy_if.phy         phy,
    output logic           spi_csn_o,
    output logic           spi_clk_o,
    output logic           spi_dat_o
);
    import xip_pkg::*;

    logic [6:0] div_cnt_q;
    logic [6:0] div_max;
    logic       tick;           // half period elapsed
    logic       busy_q;
    logic [6:0] bit_cnt_q;      // bits still to send
    frame_t     tx_q;
    word_t      rx_q;

    assign div_max = 7'((8'd1 << prsc_i) - 8'd1);
    assign tick    = busy_q && (div_cnt_q == div_max);

    // ----------------------------------------------------------------------
    // control
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q    <= 1'b0;
            spi_csn_o <= 1'b1;
            spi_clk_o <= 1'b0;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!enable_i) begin
            busy_q    <= 1'b0;          // abort, bus released
            spi_csn_o <= 1'b1;
            spi_clk_o <= 1'b0;
            div_cnt_q <= '0;
        end else if (!busy_q) begin
            div_cnt_q <= '0;
            if (phy.start) begin
                busy_q    <= 1'b1;
                spi_csn_o <= 1'b0;
                bit_cnt_q <= {phy.nbytes, 3'b000};
            end
        end else begin
            div_cnt_q <= tick ? '0 : div_cnt_q + 7'd1;
            if (tick) begin
                spi_clk_o <= ~spi_clk_o;
                if (spi_clk_o) begin    // falling edge ends a bit
                    bit_cnt_q <= bit_cnt_q - 7'd1;
                    if (bit_cnt_q == 7'd1) begin
                        busy_q    <= 1'b0;
                        spi_csn_o <= 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // shift registers
    always_ff @(posedge clk_i) begin
        if (enable_i && !busy_q && phy.start) begin
            tx_q <= phy.wdata;
        end else if (tick && spi_clk_o) begin
            tx_q <= {tx_q[`XIP_FRAME_BITS-2:0], 1'b0};     // next bit on falling edge
        end
        if (tick && !spi_clk_o) begin
            rx_q <= {rx_q[30:0], spi_dat_i};                // sample on rising edge
        end
    end

    assign spi_dat_o = busy_q & tx_q[`XIP_FRAME_BITS-1];
    assign phy.busy  = busy_q;
    assign phy.rdata = rx_q;

endmodule

`default_nettype wire

/* xip_tb.sv */
// --------------------------------------------------------------------------
// XIP controller testbench
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "xip_consts.svh"

module xip_tb;
    import xip_pkg::*;

    logic       clk_i;
    logic       rstn_i;
    reg_addr_t  ct_addr_i;
    logic       ct_rden_i;
    logic       ct_wren_i;
    word_t      ct_data_i;
    word_t      ct_data_o;
    logic       ct_ack_o;
    word_t      acc_addr_i;
    logic       acc_rden_i;
    logic       acc_wren_i;
    word_t      acc_data_o;
    logic       acc_ack_o;
    logic       acc_err_o;
    logic       xip_en_o;
    logic       xip_acc_o;
    page_t      xip_page_o;
    logic       spi_csn_o;
    logic       spi_clk_o;
    logic       spi_dat_i;
    logic       spi_dat_o;

    int         cycle_cnt   = 0;
    int         cycle_limit = 0;    // set once the trace is loaded
    int         error_cnt   = 0;
    int         csn_rises   = 0;

    // flash model state
    int         fl_abytes = 3;      // address bytes, from the trace
    int         fl_bits;
    int         fl_idx;
    logic [7:0] fl_cmd;
    logic [7:0] fl_shift;
    logic [7:0] fl_out;
    word_t      fl_addr;

    xip_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;     // 40 ns period
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("Test failures found");
            $fatal(1, "run aborted");
        end
    end

    always @(posedge spi_csn_o) csn_rises++;

    // ----------------------------------------------------------------------
    // flash model, mode 0
    function automatic logic [7:0] flash_byte(logic [7:0] cmd, word_t addr, int idx, int nab);
        word_t a;
        a = addr + 32'(idx - 1 - nab);
        if (cmd == 8'h9F) begin
            case (idx)
                1:       return 8'hC2;
                2:       return 8'h20;
                3:       return 8'h18;
                default: return 8'h00;
            endcase
        end
        if (cmd == 8'h03 && idx > nab) return a[7:0] ^ 8'h5A;  // data phase
        return 8'h00;
    endfunction

    always @(posedge spi_clk_o or negedge spi_csn_o) begin
        if (!spi_clk_o) begin               // chip select fell
            fl_bits = 0;
            fl_idx  = 0;
            fl_out  = 8'h00;
            fl_addr = '0;
            fl_cmd  = 8'h00;
        end else if (!spi_csn_o) begin
            fl_shift = {fl_shift[6:0], spi_dat_o};
            fl_bits++;
            if (fl_bits == 8) begin
                fl_bits = 0;
                if (fl_idx == 0) fl_cmd = fl_shift;
                else if (fl_idx <= fl_abytes) fl_addr = {fl_addr[23:0], fl_shift};
                fl_idx++;
                fl_out = flash_byte(fl_cmd, fl_addr, fl_idx, fl_abytes);
            end
        end
    end

    always @(negedge spi_clk_o or posedge spi_csn_o) begin
        if (spi_csn_o) spi_dat_i = 1'b0;    // first reply byte is zero
        else spi_dat_i = fl_out[3'(7 - fl_bits)];
    end

    // ----------------------------------------------------------------------
    // reporting
    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        error_cnt++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        $display("Test failures found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_event(input string what);
        error_cnt++;
        $display("at %0t: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    // ----------------------------------------------------------------------
    // bus operations
    task automatic reg_access(input reg_addr_t addr, input logic wr, input word_t wdata,
                              output word_t rdata);
        @(posedge clk_i);
        #2;
        ct_addr_i = addr;
        ct_wren_i = wr;
        ct_rden_i = !wr;
        ct_data_i = wdata;
        @(posedge clk_i);
        #2;
        ct_wren_i = 1'b0;
        ct_rden_i = 1'b0;
        assert (ct_ack_o == 1'b1) else report_mismatch("ct_ack_o", 32'(ct_ack_o), 32'h1);
        rdata = ct_data_o;                  // valid in the ack cycle
    endtask

    task automatic fetch_read(input word_t addr, input word_t exp);
        @(posedge clk_i);
        #2;
        acc_addr_i = addr;
        acc_rden_i = 1'b1;
        @(posedge clk_i);
        #2;
        acc_rden_i = 1'b0;
        while (acc_ack_o !== 1'b1) begin    // watchdog bounds this
            assert (acc_err_o == 1'b0) else report_event("error pulse on a fetch read");
            assert (xip_acc_o == 1'b1)      // fetch in flight until the ack
                else report_mismatch("xip_acc_o", 32'(xip_acc_o), 32'h1);
            @(posedge clk_i);
            #2;
        end
        assert (acc_data_o == exp) else report_mismatch("acc_data_o", acc_data_o, exp);
    endtask

    task automatic fetch_write(input word_t addr);
        @(posedge clk_i);
        #2;
        acc_addr_i = addr;
        acc_wren_i = 1'b1;
        @(posedge clk_i);
        #2;
        acc_wren_i = 1'b0;
        assert (acc_err_o == 1'b1) else report_mismatch("acc_err_o", 32'(acc_err_o), 32'h1);
    endtask

    task automatic fetch_silent(input word_t addr);
        @(posedge clk_i);
        #2;
        acc_addr_i = addr;
        acc_rden_i = 1'b1;
        @(posedge clk_i);
        #2;
        acc_rden_i = 1'b0;
        repeat (200) begin
            assert (!acc_ack_o && !acc_err_o) else report_event("response to an ignored read");
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic wait_direct_idle();
        word_t rd;
        reg_access(`XIP_REG_CTRL, 1'b0, '0, rd);
        while (rd[`XIP_CTRL_PHY_BUSY]) reg_access(`XIP_REG_CTRL, 1'b0, '0, rd);
    endtask

    task automatic poll_direct(input word_t exp);
        word_t rd;
        wait_direct_idle();
        reg_access(`XIP_REG_DATA_LO, 1'b0, '0, rd);
        assert (rd == exp) else report_mismatch("ct_data_o", rd, exp);
    endtask

    task automatic arbitrate(input word_t addr, input word_t hi, input word_t exp);
        word_t rd;
        int    rises0;
        rises0 = csn_rises;
        reg_access(`XIP_REG_DATA_HI, 1'b1, hi, rd);    // direct transfer pending
        fetch_read(addr, exp);
        wait_direct_idle();
        assert (csn_rises - rises0 >= 2)
            else report_event("chip select did not rise between the two transfers");
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    initial begin
        int    fd;
        int    n;
        int    gap;
        int    seed_val;
        string line;
        word_t op, a, d, e, rd;
        word_t ops[$];
        word_t addrs[$];
        word_t datas[$];
        word_t exps[$];

        rstn_i     = 1'b0;
        ct_addr_i  = '0;
        ct_rden_i  = 1'b0;
        ct_wren_i  = 1'b0;
        ct_data_i  = '0;
        acc_addr_i = '0;
        acc_rden_i = 1'b0;
        acc_wren_i = 1'b0;
        spi_dat_i  = 1'b0;
        seed_val   = $urandom(32'h6d6d);

        fd = $fopen("xip_trace.txt", "r");
        if (fd == 0) report_event("cannot open the trace file xip_trace.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != 8'h23) begin        // skip comment lines
                n = $sscanf(line, "%h %h %h %h", op, a, d, e);
                if (n == 4) begin
                    ops.push_back(op);
                    addrs.push_back(a);
                    datas.push_back(d);
                    exps.push_back(e);
                end
            end
        end
        $fclose(fd);
        cycle_limit = ops.size() * 4000;

        repeat (3) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        assert (spi_csn_o == 1'b1) else report_mismatch("spi_csn_o", 32'(spi_csn_o), 32'h1);
        assert (!ct_ack_o && !acc_ack_o && !acc_err_o && !xip_acc_o && !spi_clk_o)
            else report_event("outputs active after reset");

        foreach (ops[i]) begin
            gap = int'($urandom % 4);
            repeat (gap) @(posedge clk_i);
            case (ops[i])
                1: begin                                // register write
                    if (addrs[i][1:0] == `XIP_REG_CTRL)
                        fl_abytes = int'(datas[i][`XIP_CTRL_ABYTES_LSB +: 2]) + 1;
                    reg_access(addrs[i][1:0], 1'b1, datas[i], rd);
                end
                2: begin                                // register read
                    reg_access(addrs[i][1:0], 1'b0, '0, rd);
                    assert (rd == exps[i]) else report_mismatch("ct_data_o", rd, exps[i]);
                    if (addrs[i][1:0] == `XIP_REG_CTRL) begin
                        assert (xip_en_o == exps[i][0])
                            else report_mismatch("xip_en_o", 32'(xip_en_o), 32'(exps[i][0]));
                        assert (xip_page_o == exps[i][24:21])
                            else report_mismatch("xip_page_o", 32'(xip_page_o),
                                                 32'(exps[i][24:21]));
                    end
                end
                3:       fetch_read(addrs[i], exps[i]);
                4:       fetch_write(addrs[i]);
                5:       poll_direct(exps[i]);
                6:       fetch_silent(addrs[i]);
                7:       arbitrate(addrs[i], datas[i], exps[i]);
                default: report_event("unknown operation code in the trace");
            endcase
        end

        if (error_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* xip_top.sv */
// --------------------------------------------------------------------------
// XIP SPI flash controller top
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module xip_top (
    input  logic               clk_i,
    input  logic               rstn_i,
    // register port
    input  xip_pkg::reg_addr_t ct_addr_i,
    input  logic               ct_rden_i,
    input  logic               ct_wren_i,
    input  xip_pkg::word_t     ct_data_i,
    output xip_pkg::word_t     ct_data_o,
    output logic               ct_ack_o,
    // fetch port, read only window
    input  xip_pkg::word_t     acc_addr_i,
    input  logic               acc_rden_i,
    input  logic               acc_wren_i,
    output xip_pkg::word_t     acc_data_o,
    output logic               acc_ack_o,
    output logic               acc_err_o,
    // status
    output logic               xip_en_o,
    output logic               xip_acc_o,    // fetch in flight
    output xip_pkg::page_t     xip_page_o,
    // spi flash
    output logic               spi_csn_o,
    output logic               spi_clk_o,
    input  logic               spi_dat_i,
    output logic               spi_dat_o
);
    import xip_pkg::*;

    logic    xip_active;
    prsc_t   prsc;
    abytes_t abytes;
    cmd_t    rd_cmd;

    xip_req_if direct_req ();
    xip_req_if fetch_req ();
    xip_phy_if phy_if ();

    xip_ctrl_regs u_ctrl_regs (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ct_addr_i    (ct_addr_i),
        .ct_rden_i    (ct_rden_i),
        .ct_wren_i    (ct_wren_i),
        .ct_data_i    (ct_data_i),
        .ct_data_o    (ct_data_o),
        .ct_ack_o     (ct_ack_o),
        .fetch_busy_i (xip_acc_o),
        .enable_o     (xip_en_o),
        .xip_active_o (xip_active),
        .prsc_o       (prsc),
        .abytes_o     (abytes),
        .rd_cmd_o     (rd_cmd),
        .page_o       (xip_page_o),
        .direct_req   (direct_req)
    );

    xip_fetch u_fetch (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .acc_addr_i   (acc_addr_i),
        .acc_rden_i   (acc_rden_i),
        .acc_wren_i   (acc_wren_i),
        .xip_active_i (xip_active),
        .page_i       (xip_page_o),
        .abytes_i     (abytes),
        .rd_cmd_i     (rd_cmd),
        .acc_data_o   (acc_data_o),
        .acc_ack_o    (acc_ack_o),
        .acc_err_o    (acc_err_o),
        .busy_o       (xip_acc_o),
        .fetch_req    (fetch_req)
    );

    xip_spi_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .fetch_req  (fetch_req),
        .direct_req (direct_req),
        .phy        (phy_if)
    );

    xip_spi_phy u_phy (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .enable_i  (xip_en_o),
        .prsc_i    (prsc),
        .spi_dat_i (spi_dat_i),
        .phy       (phy_if),
        .spi_csn_o (spi_csn_o),
        .spi_clk_o (spi_clk_o),
        .spi_dat_o (spi_dat_o)
    );

endmodule

`default_nettype wire

/* xip_trace.txt */
# op addr data expect, all hex
# op 1 reg write, 2 reg read, 3 fetch read, 4 fetch write, 5 poll direct, 6 silent read, 7 arbitration
1 00000000 00207503 00000000
2 00000000 00000000 00207503
1 00000002 00000000 00000000
1 00000003 9f000000 00000000
5 00000000 00000000 00c22018
3 10000100 00000000 59585b5a
3 10000237 00000000 6d6c6f6e
3 1abcdef8 00000000 a1a0a3a2
3 100000fc 00000000 a5a4a7a6
1 00000000 00206503 00000000
3 10000010 00000000 49484b4a
1 00000000 00206d03 00000000
3 10001284 00000000 dddcdfde
1 00000000 00207d03 00000000
3 1ffffff0 00000000 a9a8abaa
4 10000000 00000000 00000000
6 20000000 00000000 00000000
1 00000000 00207103 00000000
6 10000100 00000000 00000000
1 00000000 00207503 00000000
7 10000100 9f000000 59585b5a
5 00000000 00000000 00c22018
